/* tlb_pkg.sv */
// tlb package with field types, page-size codes and the entry, page and search structs
package tlb_pkg;

    // virtual page-pair number, this is va[31:13]
    typedef logic [18:0] vppn_t;

    // physical page number, pa[31:12]
    typedef logic [19:0] ppn_t;

    // address space id
    typedef logic [9:0] asid_t;

    // page size given as the log2 of the page size in bytes
    typedef logic [5:0] ps_t;

    // privilege level and memory access type of one page
    typedef logic [1:0] plv_t;
    typedef logic [1:0] mat_t;

    // the two page sizes the tlb supports
    localparam ps_t ps_4k = 6'd12;
    localparam ps_t ps_4m = 6'd22;

    // one physical page of an even/odd pair
    typedef struct packed {
        ppn_t ppn;
        plv_t plv;
        mat_t mat;
        logic d;
        logic v;
    } tlb_page_t;

    // a whole tlb entry, also used for the write data and the read data
    // page0 maps the even page and page1 the odd page of the pair
    typedef struct packed {
        logic      e;
        vppn_t     vppn;
        ps_t       ps;
        asid_t     asid;
        logic      g;
        tlb_page_t page0;
        tlb_page_t page1;
    } tlb_entry_t;

    // request of one search port
    typedef struct packed {
        vppn_t vppn;
        logic  va_bit12;
        asid_t asid;
    } tlb_search_req_t;

    // response of one search port, the hit index travels next to it
    typedef struct packed {
        logic      found;
        ps_t       ps;
        tlb_page_t page;
    } tlb_search_rsp_t;

endpackage

/* tlb_entry_array.sv */
// tlb entry storage with a write port, a read port and a flat entry bus for the lookups
`timescale 1ns/1ps

module tlb_entry_array
    import tlb_pkg::*;
#(
    parameter int tlb_num = 16
) (
    input  logic                       clk_g,
    input  logic                       resetn,

    // write port, the entry at w_index is replaced at the rising edge
    input  logic                       we,
    input  logic [$clog2(tlb_num)-1:0] w_index,
    input  tlb_entry_t                 w_entry,

    // read port, combinational from the stored entries
    input  logic [$clog2(tlb_num)-1:0] r_index,
    output tlb_entry_t                 r_entry,

    // every stored entry, read by both search ports
    output tlb_entry_t [tlb_num-1:0]   entries
);

    typedef logic [$clog2(tlb_num)-1:0] idx_t;

    // one-hot write select, all low when we is low
    logic [tlb_num-1:0] wr_sel;

    // exist bits are the only state that reset touches
    logic [tlb_num-1:0] exist_q;

    // mapping fields of every entry
    vppn_t     vppn_q  [tlb_num];
    ps_t       ps_q    [tlb_num];
    asid_t     asid_q  [tlb_num];
    logic      g_q     [tlb_num];
    tlb_page_t page0_q [tlb_num];
    tlb_page_t page1_q [tlb_num];

    always_comb begin
        for (int i = 0; i < tlb_num; i++) begin
            wr_sel[i] = we && (w_index == idx_t'(i));
        end
    end

    // a cleared exist bit hides the entry from read and search alike
    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            exist_q <= '0;
        end else begin
            exist_q <= (exist_q & ~wr_sel) | (wr_sel & {tlb_num{w_entry.e}});
        end
    end

    always_ff @(posedge clk_g) begin
        for (int i = 0; i < tlb_num; i++) begin
            if (wr_sel[i]) begin
                vppn_q[i]  <= w_entry.vppn;
                ps_q[i]    <= w_entry.ps;
                asid_q[i]  <= w_entry.asid;
                g_q[i]     <= w_entry.g;
                page0_q[i] <= w_entry.page0;
                page1_q[i] <= w_entry.page1;
            end
        end
    end

    // rebuild the entries from the exist bits and the mapping fields
    always_comb begin
        for (int i = 0; i < tlb_num; i++) begin
            entries[i].e     = exist_q[i];
            entries[i].vppn  = vppn_q[i];
            entries[i].ps    = ps_q[i];
            entries[i].asid  = asid_q[i];
            entries[i].g     = g_q[i];
            entries[i].page0 = page0_q[i];
            entries[i].page1 = page1_q[i];
        end
    end

    // tlb_num is a power of two, so every index value names an entry
    assign r_entry = entries[r_index];

endmodule

/* tlb_lookup.sv */
// tlb search port that matches all entries, picks the lowest hit and selects its page
`timescale 1ns/1ps

module tlb_lookup
    import tlb_pkg::*;
#(
    parameter int tlb_num = 16
) (
    input  tlb_entry_t [tlb_num-1:0]   entries,
    input  tlb_search_req_t            req,
    output tlb_search_rsp_t            rsp,
    output logic [$clog2(tlb_num)-1:0] index
);

    typedef logic [$clog2(tlb_num)-1:0] idx_t;

    localparam int vppn_w = $bits(vppn_t);

    // vppn bits that a 4 MB page pair does not compare, the top one of
    // them picks the odd page of such a pair
    localparam int lo_w = int'(ps_4m) - int'(ps_4k);

    // per-entry compare results
    logic [tlb_num-1:0] hi_eq;
    logic [tlb_num-1:0] lo_eq;
    logic [tlb_num-1:0] asid_ok;
    logic [tlb_num-1:0] hit;

    // the winning entry
    logic       hit_any;
    idx_t       hit_idx;
    tlb_entry_t hit_entry;
    logic       odd_sel;
    tlb_page_t  hit_page;

    always_comb begin
        for (int i = 0; i < tlb_num; i++) begin
            hi_eq[i] = entries[i].vppn[vppn_w-1:lo_w] == req.vppn[vppn_w-1:lo_w];

            // the low vppn bits only count for a 4 KB page pair
            lo_eq[i] = (entries[i].ps == ps_4m)
                    || (entries[i].vppn[lo_w-1:0] == req.vppn[lo_w-1:0]);

            // a global entry hits under any asid
            asid_ok[i] = entries[i].g || (entries[i].asid == req.asid);

            hit[i] = entries[i].e && hi_eq[i] && lo_eq[i] && asid_ok[i];
        end
    end

    // priority encoder, scanning downwards so that the lowest hit is kept
    always_comb begin
        hit_idx = '0;
        for (int i = tlb_num - 1; i >= 0; i--) begin
            if (hit[i]) begin
                hit_idx = idx_t'(i);
            end
        end
    end

    assign hit_any   = |hit;
    assign hit_entry = entries[hit_idx];

    // va bit 12 splits a 4 KB pair, va bit 22 (vppn bit 9) a 4 MB pair
    assign odd_sel  = (hit_entry.ps == ps_4m) ? req.vppn[lo_w-1] : req.va_bit12;
    assign hit_page = odd_sel ? hit_entry.page1 : hit_entry.page0;

    // on a miss every response field reads as zero
    always_comb begin
        rsp.found = hit_any;
        rsp.ps    = hit_any ? hit_entry.ps : '0;
        rsp.page  = hit_any ? hit_page : '0;
    end

    // hit_idx already falls back to zero when nothing hits
    assign index = hit_idx;

endmodule

/* tlb_top.sv */
// fully associative tlb with one write port, one read port and two search ports
`timescale 1ns/1ps

module tlb_top
    import tlb_pkg::*;
#(
    parameter int tlb_num = 16
) (
    input  logic                       clk_g,
    input  logic                       resetn,

    // write port
    input  logic                       we,
    input  logic [$clog2(tlb_num)-1:0] w_index,
    input  tlb_entry_t                 w_entry,

    // read port
    input  logic [$clog2(tlb_num)-1:0] r_index,
    output tlb_entry_t                 r_entry,

    // search port 0
    input  tlb_search_req_t            s0_req,
    output tlb_search_rsp_t            s0_rsp,
    output logic [$clog2(tlb_num)-1:0] s0_index,

    // search port 1
    input  tlb_search_req_t            s1_req,
    output tlb_search_rsp_t            s1_rsp,
    output logic [$clog2(tlb_num)-1:0] s1_index
);

    // stored entries, shared by both search ports which never contend
    tlb_entry_t [tlb_num-1:0] entries;

    tlb_entry_array #(
        .tlb_num (tlb_num)
    ) array (
        .clk_g   (clk_g),
        .resetn  (resetn),
        .we      (we),
        .w_index (w_index),
        .w_entry (w_entry),
        .r_index (r_index),
        .r_entry (r_entry),
        .entries (entries)
    );

    // a search sees the contents from before a write in the same cycle
    tlb_lookup #(
        .tlb_num (tlb_num)
    ) lookup0 (
        .entries (entries),
        .req     (s0_req),
        .rsp     (s0_rsp),
        .index   (s0_index)
    );

    tlb_lookup #(
        .tlb_num (tlb_num)
    ) lookup1 (
        .entries (entries),
        .req     (s1_req),
        .rsp     (s1_rsp),
        .index   (s1_index)
    );

endmodule

/* tb_tlb_tables.svh */
// reference tlb write table and directed dual-port search pairs for the tlb testbench
`ifndef TB_TLB_TABLES_SVH
`define TB_TLB_TABLES_SVH

localparam int search_num = 13;

tlb_entry_t      wr_table  [tlb_num];
tlb_search_req_t search_s0 [search_num];
tlb_search_req_t search_s1 [search_num];

// present entry with fixed attributes, the odd page is the clean one
function automatic tlb_entry_t make_entry(input vppn_t vppn, input ps_t ps, input asid_t asid,
                                          input logic g, input ppn_t ppn0, input ppn_t ppn1);
    tlb_entry_t ent;
    ent.e     = 1'b1;
    ent.vppn  = vppn;
    ent.ps    = ps;
    ent.asid  = asid;
    ent.g     = g;
    ent.page0 = '{ppn: ppn0, plv: ppn0[1:0], mat: 2'd1, d: 1'b1, v: 1'b1};
    ent.page1 = '{ppn: ppn1, plv: ppn1[1:0], mat: 2'd1, d: 1'b0, v: 1'b1};
    return ent;
endfunction

function automatic tlb_search_req_t make_req(input vppn_t vppn, input logic va_bit12,
                                             input asid_t asid);
    tlb_search_req_t req;
    req.vppn     = vppn;
    req.va_bit12 = va_bit12;
    req.asid     = asid;
    return req;
endfunction

task automatic load_tables();
    // columns are vppn, page size, asid, global, even ppn, odd ppn
    wr_table[0]  = make_entry(19'h00000, ps_4k, 10'h000, 1'b0, 20'h00010, 20'h00011);
    wr_table[1]  = make_entry(19'h00001, ps_4k, 10'h000, 1'b0, 20'h00012, 20'h00013);
    wr_table[2]  = make_entry(19'h00002, ps_4k, 10'h001, 1'b0, 20'h00020, 20'h00021);
    wr_table[3]  = make_entry(19'h00002, ps_4k, 10'h002, 1'b0, 20'h00030, 20'h00031);
    wr_table[4]  = make_entry(19'h10400, ps_4m, 10'h003, 1'b0, 20'h41000, 20'h41400);
    wr_table[5]  = make_entry(19'h20800, ps_4m, 10'h004, 1'b1, 20'h82000, 20'h82400);
    wr_table[6]  = make_entry(19'h03003, ps_4k, 10'h005, 1'b1, 20'h03006, 20'h03007);
    wr_table[7]  = make_entry(19'h7fffe, ps_4k, 10'h3ff, 1'b0, 20'hffffc, 20'hffffd);
    wr_table[8]  = make_entry(19'h00400, ps_4k, 10'h010, 1'b0, 20'h00800, 20'h00801);
    wr_table[9]  = make_entry(19'h00401, ps_4k, 10'h010, 1'b0, 20'h00802, 20'h00803);
    wr_table[10] = make_entry(19'h30c00, ps_4m, 10'h011, 1'b0, 20'hc3000, 20'hc3400);
    wr_table[11] = make_entry(19'h05555, ps_4k, 10'h012, 1'b0, 20'h0aaaa, 20'h0aaab);
    wr_table[12] = make_entry(19'h0aaaa, ps_4k, 10'h013, 1'b1, 20'h15554, 20'h15555);
    wr_table[13] = make_entry(19'h12345, ps_4k, 10'h014, 1'b0, 20'h2468a, 20'h2468b);
    wr_table[14] = make_entry(19'h23456, ps_4k, 10'h015, 1'b0, 20'h468ac, 20'h468ad);
    wr_table[15] = make_entry(19'h34567, ps_4k, 10'h016, 1'b0, 20'h68ace, 20'h68acf);

    // search pairs, each request is vppn, va bit 12, asid
    search_s0[0]  = make_req(19'h00000, 1'b0, 10'h000);
    search_s1[0]  = make_req(19'h00001, 1'b1, 10'h000);
    search_s0[1]  = make_req(19'h00002, 1'b0, 10'h001);
    search_s1[1]  = make_req(19'h00002, 1'b1, 10'h002);
    search_s0[2]  = make_req(19'h00002, 1'b0, 10'h003);
    search_s1[2]  = make_req(19'h00000, 1'b0, 10'h001);
    search_s0[3]  = make_req(19'h10400, 1'b0, 10'h003);
    search_s1[3]  = make_req(19'h10600, 1'b0, 10'h003);
    search_s0[4]  = make_req(19'h105ff, 1'b1, 10'h003);
    search_s1[4]  = make_req(19'h10400, 1'b0, 10'h004);
    search_s0[5]  = make_req(19'h20800, 1'b0, 10'h000);
    search_s1[5]  = make_req(19'h20a00, 1'b1, 10'h3ff);
    search_s0[6]  = make_req(19'h03003, 1'b1, 10'h200);
    search_s1[6]  = make_req(19'h03003, 1'b0, 10'h005);
    search_s0[7]  = make_req(19'h7fffe, 1'b1, 10'h3ff);
    search_s1[7]  = make_req(19'h7ffff, 1'b0, 10'h3ff);
    search_s0[8]  = make_req(19'h00400, 1'b0, 10'h010);
    search_s1[8]  = make_req(19'h00401, 1'b1, 10'h010);
    search_s0[9]  = make_req(19'h30fff, 1'b1, 10'h011);
    search_s1[9]  = make_req(19'h31000, 1'b0, 10'h011);
    search_s0[10] = make_req(19'h0aaaa, 1'b0, 10'h123);
    search_s1[10] = make_req(19'h12345, 1'b1, 10'h014);
    search_s0[11] = make_req(19'h23456, 1'b0, 10'h016);
    search_s1[11] = make_req(19'h34567, 1'b1, 10'h016);
    search_s0[12] = make_req(19'h44444, 1'b0, 10'h000);
    search_s1[12] = make_req(19'h05555, 1'b1, 10'h012);
endtask

`endif

/* tb_tlb.sv */
// testbench for the dual search port tlb, checked against a reference model
`timescale 1ns/1ps

module tb_tlb
    import tlb_pkg::*;
();

    localparam int tlb_num       = 16;
    localparam int idx_w         = $clog2(tlb_num);
    localparam int half_period   = 50;
    localparam int settle        = 20;
    localparam int reset_cycles  = 10;
    localparam int reset_timeout = 20;
    localparam int random_cycles = 400;

    typedef logic [idx_w-1:0] idx_t;

    logic            clk_g = 1'b0;
    logic            resetn;
    logic            we;
    idx_t            w_index;
    tlb_entry_t      w_entry;
    idx_t            r_index;
    tlb_entry_t      r_entry;
    tlb_search_req_t s0_req;
    tlb_search_rsp_t s0_rsp;
    idx_t            s0_index;
    tlb_search_req_t s1_req;
    tlb_search_rsp_t s1_rsp;
    idx_t            s1_index;

    // reference copy of the entries, known marks entries written at least once
    tlb_entry_t model       [tlb_num];
    logic       model_known [tlb_num];

    int    errors;
    int    errors_at_start;
    int    pass_count;
    int    fail_count;
    string test_name;
    bit    timed_out;

    `include "tb_tlb_tables.svh"

    tlb_top #(
        .tlb_num (tlb_num)
    ) dut (
        .clk_g    (clk_g),
        .resetn   (resetn),
        .we       (we),
        .w_index  (w_index),
        .w_entry  (w_entry),
        .r_index  (r_index),
        .r_entry  (r_entry),
        .s0_req   (s0_req),
        .s0_rsp   (s0_rsp),
        .s0_index (s0_index),
        .s1_req   (s1_req),
        .s1_rsp   (s1_rsp),
        .s1_index (s1_index)
    );

    initial begin
        forever begin
            #half_period;
            clk_g = ~clk_g;
        end
    end

    task automatic compare_value(input string name, input logic [127:0] expected,
                                 input logic [127:0] actual);
        assert (actual === expected) else begin
            $display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, expected,
                     actual);
            errors++;
        end
    endtask

    // first matching entry in index order, with the page picked by the odd bit
    function automatic void model_search(input tlb_search_req_t req,
                                         output tlb_search_rsp_t rsp, output idx_t idx);
        tlb_entry_t ent;
        logic       vppn_ok;
        logic       odd;
        rsp = '0;
        idx = '0;
        for (int i = 0; i < tlb_num; i++) begin
            ent = model[i];
            if (ent.ps == ps_4m) begin
                vppn_ok = ent.vppn[18:10] == req.vppn[18:10];
            end else begin
                vppn_ok = ent.vppn == req.vppn;
            end
            if (!rsp.found && ent.e && (ent.g || ent.asid == req.asid) && vppn_ok) begin
                odd       = (ent.ps == ps_4m) ? req.vppn[9] : req.va_bit12;
                rsp.found = 1'b1;
                rsp.ps    = ent.ps;
                rsp.page  = odd ? ent.page1 : ent.page0;
                idx       = idx_t'(i);
            end
        end
    endfunction

    task automatic check_read();
        tlb_entry_t exp;
        exp = model[r_index];
        compare_value("r_entry.e", exp.e, r_entry.e);
        if (model_known[r_index]) begin
            compare_value("r_entry.vppn", exp.vppn, r_entry.vppn);
            compare_value("r_entry.ps", exp.ps, r_entry.ps);
            compare_value("r_entry.asid", exp.asid, r_entry.asid);
            compare_value("r_entry.g", exp.g, r_entry.g);
            compare_value("r_entry.page0", exp.page0, r_entry.page0);
            compare_value("r_entry.page1", exp.page1, r_entry.page1);
        end
    endtask

    task automatic check_search(input string port, input tlb_search_req_t req,
                                input tlb_search_rsp_t rsp, input idx_t index);
        tlb_search_rsp_t exp_rsp;
        idx_t            exp_index;
        model_search(req, exp_rsp, exp_index);
        compare_value({port, "_rsp.found"}, exp_rsp.found, rsp.found);
        compare_value({port, "_rsp.ps"}, exp_rsp.ps, rsp.ps);
        compare_value({port, "_rsp.page"}, exp_rsp.page, rsp.page);
        compare_value({port, "_index"}, exp_index, index);
    endtask

    // outputs are checked well before the rising edge, so against the old contents
    task automatic settle_and_check();
        #settle;
        check_read();
        check_search("s0", s0_req, s0_rsp, s0_index);
        check_search("s1", s1_req, s1_rsp, s1_index);
    endtask

    task automatic advance();
        @(posedge clk_g);
        if (we) begin
            model[w_index]       = w_entry;
            model_known[w_index] = 1'b1;
        end
        @(negedge clk_g);
    endtask

    task automatic step();
        settle_and_check();
        advance();
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        if (errors == errors_at_start) begin
            pass_count++;
            $display("test %s: ok", test_name);
        end else begin
            fail_count++;
            $display("test %s: %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    task automatic wait_reset_done(output bit ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < reset_timeout) begin
            #settle;
            if (r_entry.e === 1'b0 && s0_rsp.found === 1'b0 && s1_rsp.found === 1'b0) begin
                ok = 1'b1;
            end
            @(negedge clk_g);
            cycles++;
        end
        if (!ok) begin
            $display("timed out after %0d cycles waiting for the TLB to clear after reset",
                     reset_timeout);
        end
    endtask

    // mostly the mapping of a stored entry so that searches hit often
    function automatic tlb_search_req_t random_req();
        tlb_search_req_t req;
        tlb_entry_t      ent;
        req.vppn     = vppn_t'($urandom);
        req.va_bit12 = 1'($urandom);
        req.asid     = asid_t'($urandom);
        if ($urandom % 4 != 0) begin
            ent      = model[$urandom % tlb_num];
            req.vppn = ent.vppn;
            if (ent.ps == ps_4m) begin
                req.vppn[9:0] = 10'($urandom);
            end
            if ($urandom % 4 != 0) begin
                req.asid = ent.asid;
            end
        end
        return req;
    endfunction

    // small vppn and asid pools make duplicates and overlaps common
    function automatic tlb_entry_t random_entry();
        tlb_entry_t ent;
        ent.e     = ($urandom % 8) != 0;
        ent.vppn  = {9'($urandom % 4), 10'($urandom % 8)};
        ent.ps    = ($urandom % 4 == 0) ? ps_4m : ps_4k;
        ent.asid  = asid_t'($urandom % 4);
        ent.g     = ($urandom % 8) == 0;
        ent.page0 = tlb_page_t'(26'($urandom));
        ent.page1 = tlb_page_t'(26'($urandom));
        return ent;
    endfunction

    task automatic run_all();
        bit         ok;
        tlb_entry_t ent;
        begin_test("reset");
        repeat (reset_cycles) @(negedge clk_g);
        resetn = 1'b1;
        wait_reset_done(ok);
        if (!ok) begin
            timed_out = 1'b1;
            return;
        end
        for (int i = 0; i < tlb_num; i++) begin
            r_index = idx_t'(i);
            s0_req  = random_req();
            s1_req  = random_req();
            step();
        end
        end_test();

        begin_test("write and read back");
        we = 1'b1;
        for (int i = 0; i < tlb_num; i++) begin
            w_index = idx_t'(i);
            w_entry = wr_table[i];
            r_index = idx_t'(i);
            step();
        end
        we = 1'b0;
        for (int i = 0; i < tlb_num; i++) begin
            r_index = idx_t'(i);
            step();
        end
        end_test();

        begin_test("directed search");
        for (int k = 0; k < search_num; k++) begin
            s0_req  = search_s0[k];
            s1_req  = search_s1[k];
            r_index = idx_t'(k);
            step();
        end
        end_test();

        begin_test("priority");
        ent     = make_entry(19'h55555, ps_4k, 10'h020, 1'b1, 20'h55550, 20'h55551);
        we      = 1'b1;
        w_index = idx_t'(13);
        w_entry = ent;
        step();
        w_index             = idx_t'(9);
        w_entry.page0.ppn   = 20'h99990;
        step();
        we     = 1'b0;
        s0_req = make_req(19'h55555, 1'b0, 10'h021);
        s1_req = make_req(19'h55555, 1'b1, 10'h3aa);
        settle_and_check();
        compare_value("s0_index", 9, s0_index);
        compare_value("s1_index", 9, s1_index);
        advance();
        end_test();

        begin_test("overwrite ordering");
        ent     = make_entry(19'h0abcd, ps_4k, 10'h001, 1'b0, 20'h0abc0, 20'h0abc1);
        we      = 1'b1;
        w_index = idx_t'(2);
        w_entry = ent;
        s0_req  = make_req(19'h00002, 1'b0, 10'h001);
        s1_req  = make_req(19'h0abcd, 1'b1, 10'h001);
        settle_and_check();
        compare_value("s0_rsp.found", 1, s0_rsp.found);
        compare_value("s1_rsp.found", 0, s1_rsp.found);
        advance();
        we = 1'b0;
        settle_and_check();
        compare_value("s0_rsp.found", 0, s0_rsp.found);
        compare_value("s1_rsp.found", 1, s1_rsp.found);
        compare_value("s1_index", 2, s1_index);
        advance();
        ent.e   = 1'b0;
        we      = 1'b1;
        w_entry = ent;
        step();
        we = 1'b0;
        settle_and_check();
        compare_value("s1_rsp.found", 0, s1_rsp.found);
        advance();
        end_test();

        begin_test("random traffic");
        for (int c = 0; c < random_cycles; c++) begin
            we      = ($urandom % 3) == 0;
            w_index = idx_t'($urandom);
            w_entry = random_entry();
            r_index = idx_t'($urandom);
            s0_req  = random_req();
            s1_req  = random_req();
            step();
        end
        we = 1'b0;
        end_test();
    endtask

    initial begin
        void'($urandom(32'hf094));
        resetn     = 1'b0;
        we         = 1'b0;
        w_index    = '0;
        w_entry    = '0;
        r_index    = '0;
        s0_req     = '0;
        s1_req     = '0;
        errors     = 0;
        pass_count = 0;
        fail_count = 0;
        timed_out  = 1'b0;
        for (int i = 0; i < tlb_num; i++) begin
            model[i]       = '0;
            model_known[i] = 1'b0;
        end
        load_tables();
        run_all();
        $display("tests passed %0d, failed %0d, errors %0d", pass_count, fail_count, errors);
        if (timed_out || errors != 0) begin
            $display("SIMULATION FAILED");
        end else begin
            $display("SIMULATION PASSED");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+.
tlb_pkg.sv
tlb_entry_array.sv
tlb_lookup.sv
tlb_top.sv
tb_tlb.sv

/* Bender.yml */
package:
  name: tlb

dependencies: {}

sources:
  - files:
      - tlb_pkg.sv
      - tlb_entry_array.sv
      - tlb_lookup.sv
      - tlb_top.sv

  - target: test
    include_dirs:
      - .
    files:
      - tb_tlb.sv
